// File: rtl/alu.sv
`timescale 1ns/10ps

module alu (
    input  calc_pkg::calc_cmd_t cmd,
    output calc_pkg::calc_wide_t result
);

    calc_pkg::calc_word_t lo;

    // Everything but mul fits in the low word
    always_comb begin
        lo = '0;
        case (cmd.op)
            calc_pkg::op_add: lo = cmd.a + cmd.b;
            calc_pkg::op_sub: lo = cmd.a - cmd.b;
            calc_pkg::op_and: lo = cmd.a & cmd.b;
            calc_pkg::op_or:  lo = cmd.a | cmd.b;
            calc_pkg::op_xor: lo = cmd.a ^ cmd.b;
            calc_pkg::op_shl: lo = cmd.a << cmd.b[4:0];
            calc_pkg::op_shr: lo = cmd.a >> cmd.b[4:0];
            default:          lo = '0;
        endcase
    end

    always_comb begin
        if (cmd.op == calc_pkg::op_mul) begin
            result = {32'd0, cmd.a} * {32'd0, cmd.b};
        end else begin
            result = {32'd0, lo};
        end
    end

endmodule

// File: rtl/calc_pkg.sv
package calc_pkg;

    // Operand, or one half of a result
    typedef logic [31:0] calc_word_t;

    // Full ALU result
    typedef logic [63:0] calc_wide_t;

    // Words received so far in the current command
    typedef logic [1:0] word_count_t;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_mul = 4'd2,
        op_and = 4'd3,
        op_or  = 4'd4,
        op_xor = 4'd5,
        op_shl = 4'd6,
        op_shr = 4'd7
    } calc_op_t;

    typedef struct packed {
        calc_word_t a;
        calc_word_t b;
        calc_op_t   op;
    } calc_cmd_t;

endpackage

// File: rtl/command_buffer.sv
`timescale 1ns/10ps

module command_buffer (
    input  logic                  clock,
    input  logic                  rst,
    input  calc_pkg::calc_word_t  word,
    input  logic                  word_done,
    input  logic                  line_idle,
    output calc_pkg::calc_cmd_t   cmd,
    output logic                  cmd_done,
    output calc_pkg::word_count_t word_count
);

    calc_pkg::calc_word_t a_q;
    calc_pkg::calc_word_t b_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            word_count <= '0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (line_idle) begin
                // Held command stays for the ALU
                word_count <= '0;
            end else if (word_done) begin
                case (word_count)
                    2'd0: begin
                        a_q <= word;
                        word_count <= 2'd1;
                    end
                    2'd1: begin
                        b_q <= word;
                        word_count <= 2'd2;
                    end
                    default: begin
                        cmd.a <= a_q;
                        cmd.b <= b_q;
                        cmd.op <= calc_pkg::calc_op_t'(word[3:0]);
                        cmd_done <= 1'b1;
                        word_count <= '0;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/result_tx.sv
`timescale 1ns/10ps

module result_tx (
    input  logic                 clock,
    input  logic                 rst,
    input  calc_pkg::calc_wide_t result,
    input  logic                 cmd_done,
    input  logic                 tx_done,
    output uart_pkg::uart_byte_t tx_byte,
    output logic                 tx_send
);

    calc_pkg::calc_wide_t data;
    logic [2:0] idx;
    logic active;

    // Latched result goes out low byte first
    assign tx_byte = data[idx*8 +: 8];

    always_ff @(posedge clock) begin
        if (rst) begin
            idx <= '0;
            active <= 1'b0;
            tx_send <= 1'b0;
        end else begin
            tx_send <= 1'b0;
            if (cmd_done) begin
                data <= result;
                idx <= '0;
                active <= 1'b1;
                tx_send <= 1'b1;
            end else if (active && tx_done) begin
                if (idx == 3'd7) begin
                    active <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                    tx_send <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/uart_calc.sv
`timescale 1ns/10ps

module uart_calc #(
    parameter int cycles_per_bit = uart_pkg::cycles_per_bit
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  uart_in,
    output logic                  uart_out,
    output calc_pkg::word_count_t word_count
);

    uart_pkg::uart_byte_t rx_byte;
    logic rx_done;
    logic line_idle;
    calc_pkg::calc_word_t word;
    logic word_done;
    calc_pkg::calc_cmd_t cmd;
    logic cmd_done;
    calc_pkg::calc_wide_t result;
    uart_pkg::uart_byte_t tx_byte;
    logic tx_send;
    logic tx_done;

    // Producer
    uart_rx #(.cycles_per_bit(cycles_per_bit)) u_uart_rx (
        .clock(clock),
        .rst(rst),
        .rx(uart_in),
        .rx_byte(rx_byte),
        .rx_done(rx_done),
        .line_idle(line_idle)
    );

    word_rx u_word_rx (
        .clock(clock),
        .rst(rst),
        .rx_byte(rx_byte),
        .rx_done(rx_done),
        .line_idle(line_idle),
        .word(word),
        .word_done(word_done)
    );

    command_buffer u_command_buffer (
        .clock(clock),
        .rst(rst),
        .word(word),
        .word_done(word_done),
        .line_idle(line_idle),
        .cmd(cmd),
        .cmd_done(cmd_done),
        .word_count(word_count)
    );

    // Consumer
    alu u_alu (
        .cmd(cmd),
        .result(result)
    );

    result_tx u_result_tx (
        .clock(clock),
        .rst(rst),
        .result(result),
        .cmd_done(cmd_done),
        .tx_done(tx_done),
        .tx_byte(tx_byte),
        .tx_send(tx_send)
    );

    uart_tx #(.cycles_per_bit(cycles_per_bit)) u_uart_tx (
        .clock(clock),
        .rst(rst),
        .tx_byte(tx_byte),
        .tx_send(tx_send),
        .tx(uart_out),
        .tx_done(tx_done)
    );

endmodule

// File: rtl/uart_pkg.sv
package uart_pkg;

    // One data byte on the serial line
    typedef logic [7:0] uart_byte_t;

    // Default bit period in clock cycles
    localparam int cycles_per_bit = 104;

    // Idle bit periods before a partial command is dropped
    localparam int idle_bits = 32;

    // Data bits in an 8N1 frame
    localparam int data_bits = 8;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int cycles_per_bit = uart_pkg::cycles_per_bit
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 rx,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_done,
    output logic                 line_idle
);

    localparam int cnt_w = $clog2(cycles_per_bit);
    localparam int idle_w = $clog2(uart_pkg::idle_bits);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(cycles_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(cycles_per_bit / 2 - 1);
    localparam logic [idle_w-1:0] idle_last = idle_w'(uart_pkg::idle_bits - 1);
    localparam logic [2:0] bit_idx_last = 3'(uart_pkg::data_bits - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;
    logic [2:0] rx_sync;
    logic [cnt_w-1:0] cnt;
    logic [2:0] bit_idx;
    logic [idle_w-1:0] idle_cnt;
    logic armed;
    logic rx_s;
    logic start_edge;

    // Two flops for the async line, a third for edge detection
    assign rx_s = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];

    always_ff @(posedge clock) begin
        if (rst) begin
            rx_sync <= '1;
            state <= st_idle;
            cnt <= '0;
            bit_idx <= '0;
            idle_cnt <= '0;
            armed <= 1'b0;
            rx_done <= 1'b0;
            line_idle <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
            rx_done <= 1'b0;
            line_idle <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_edge) begin
                        state <= st_start;
                        cnt <= '0;
                        idle_cnt <= '0;
                        armed <= 1'b1;
                    end else if (!rx_s || !armed) begin
                        cnt <= '0;
                        idle_cnt <= '0;
                    end else if (cnt == bit_last) begin
                        // One more bit period of high line
                        cnt <= '0;
                        if (idle_cnt == idle_last) begin
                            idle_cnt <= '0;
                            armed <= 1'b0;
                            line_idle <= 1'b1;
                        end else begin
                            idle_cnt <= idle_cnt + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_start: begin
                    // Start bit must still be low at mid-bit
                    if (cnt == half_last) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_s ? st_idle : st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (cnt == bit_last) begin
                        cnt <= '0;
                        rx_byte <= {rx_s, rx_byte[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_last) begin
                            state <= st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (cnt == bit_last) begin
                        cnt <= '0;
                        rx_done <= rx_s;    // bad stop bit drops the byte
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int cycles_per_bit = uart_pkg::cycles_per_bit
) (
    input  logic                 clock,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic                 tx_send,
    output logic                 tx,
    output logic                 tx_done
);

    localparam int cnt_w = $clog2(cycles_per_bit);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(cycles_per_bit - 1);
    localparam logic [2:0] bit_idx_last = 3'(uart_pkg::data_bits - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;
    logic [cnt_w-1:0] cnt;
    logic [2:0] bit_idx;
    uart_pkg::uart_byte_t shift;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= st_idle;
            cnt <= '0;
            bit_idx <= '0;
            tx <= 1'b1;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (tx_send) begin
                        shift <= tx_byte;
                        tx <= 1'b0;
                        cnt <= '0;
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (cnt == bit_last) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        tx <= shift[0];
                        shift <= shift >> 1;
                        state <= st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (cnt == bit_last) begin
                        cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_last) begin
                            tx <= 1'b1;
                            state <= st_stop;
                        end else begin
                            tx <= shift[0];
                            shift <= shift >> 1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (cnt == bit_last) begin
                        cnt <= '0;
                        tx_done <= 1'b1;
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: rtl/word_rx.sv
`timescale 1ns/10ps

module word_rx (
    input  logic                 clock,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t rx_byte,
    input  logic                 rx_done,
    input  logic                 line_idle,
    output calc_pkg::calc_word_t word,
    output logic                 word_done
);

    logic [1:0] byte_cnt;

    always_ff @(posedge clock) begin
        if (rst) begin
            byte_cnt <= '0;
            word_done <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (line_idle) begin
                byte_cnt <= '0;
            end else if (rx_done) begin
                // First byte ends up in the low eight bits
                word <= {rx_byte, word[31:8]};
                byte_cnt <= byte_cnt + 1'b1;
                word_done <= (byte_cnt == 2'd3);
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module uart_calc_tb -f sources.f -o uart_calc_sim \
    && ./obj_dir/uart_calc_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: sources.f
rtl/uart_pkg.sv
rtl/calc_pkg.sv
rtl/uart_rx.sv
rtl/word_rx.sv
rtl/command_buffer.sv
rtl/alu.sv
rtl/result_tx.sv
rtl/uart_tx.sv
rtl/uart_calc.sv
verif/uart_calc_sva.sv
verif/uart_calc_tb.sv

// File: verif/uart_calc_sva.sv
`timescale 1ns/10ps

module uart_calc_sva (
    input logic       clock,
    input logic       rst,
    input logic       uart_out,
    input logic       tx_send,
    input logic       cmd_done,
    input logic [1:0] tx_state
);

    // st_idle is the first state of the transmitter FSM
    localparam logic [1:0] tx_idle = 2'd0;

    // No back-pressure, so a send into a busy transmitter would be lost
    send_only_when_idle: assert property (
        @(posedge clock) disable iff (rst) tx_send |-> tx_state == tx_idle
    ) else $error("tx_send while the transmitter is busy");

    line_high_when_idle: assert property (
        @(posedge clock) disable iff (rst) tx_state == tx_idle |-> uart_out
    ) else $error("uart_out low while the transmitter is idle");

    single_cmd_done: assert property (
        @(posedge clock) disable iff (rst) cmd_done |=> !cmd_done
    ) else $error("cmd_done high for two cycles in a row");

endmodule

bind uart_calc uart_calc_sva sva (
    .clock(clock),
    .rst(rst),
    .uart_out(uart_out),
    .tx_send(tx_send),
    .cmd_done(cmd_done),
    .tx_state(u_uart_tx.state)
);

// File: verif/uart_calc_tb.sv
`timescale 1ns/10ps

module uart_calc_tb;

    localparam int bit_cycles = 16;
    localparam int wait_limit = 4000;
    localparam int random_cmds = 20;

    logic clock;
    logic rst;
    logic uart_in;
    logic uart_out;
    calc_pkg::word_count_t word_count;

    int errors;
    int checks;
    int seed;

    uart_calc #(.cycles_per_bit(bit_cycles)) uut (
        .clock(clock),
        .rst(rst),
        .uart_in(uart_in),
        .uart_out(uart_out),
        .word_count(word_count)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic calc_pkg::calc_cmd_t make_cmd(input logic [31:0] a,
                                                     input logic [31:0] b,
                                                     input logic [3:0] op);
        calc_pkg::calc_cmd_t c;
        c.a = a;
        c.b = b;
        c.op = calc_pkg::calc_op_t'(op);
        return c;
    endfunction

    // Expected reply from the operation table
    function automatic calc_pkg::calc_wide_t model_result(input calc_pkg::calc_cmd_t c);
        logic [31:0] pow2;
        logic [63:0] r;
        pow2 = 32'd1 << c.b[4:0];
        case (c.op)
            calc_pkg::op_add: r = {32'd0, c.a + c.b};
            calc_pkg::op_sub: r = {32'd0, c.a + ~c.b + 32'd1};
            calc_pkg::op_mul: r = 64'(c.a) * 64'(c.b);
            calc_pkg::op_and: r = {32'd0, c.a & c.b};
            calc_pkg::op_or:  r = {32'd0, c.a | c.b};
            calc_pkg::op_xor: r = {32'd0, c.a ^ c.b};
            calc_pkg::op_shl: r = {32'd0, c.a * pow2};
            calc_pkg::op_shr: r = {32'd0, c.a / pow2};
            default:          r = 64'd0;
        endcase
        return r;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // 8N1 frame with bits changing on falling edges
    task automatic send_byte(input uart_pkg::uart_byte_t b);
        uart_in = 1'b0;
        repeat (bit_cycles) @(negedge clock);
        for (int i = 0; i < 8; i++) begin
            uart_in = b[i];
            repeat (bit_cycles) @(negedge clock);
        end
        uart_in = 1'b1;
        repeat (bit_cycles) @(negedge clock);
    endtask

    task automatic send_word(input calc_pkg::calc_word_t w);
        for (int k = 0; k < 4; k++) begin
            send_byte(w[8*k +: 8]);
        end
    endtask

    task automatic send_cmd(input calc_pkg::calc_cmd_t c);
        send_word(c.a);
        send_word(c.b);
        send_word({28'd0, c.op});
    endtask

    task automatic recv_result(output calc_pkg::calc_wide_t value);
        int n;
        value = '0;
        for (int k = 0; k < 8; k++) begin
            n = 0;
            while (uart_out !== 1'b0 && n < wait_limit) begin
                @(negedge clock);
                n++;
            end
            if (uart_out !== 1'b0) begin
                errors++;
                $display("timeout waiting for reply");
                return;
            end
            // Middle of the start bit, then one bit period per data bit
            repeat (bit_cycles / 2) @(negedge clock);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_cycles) @(negedge clock);
                value[8*k + i] = uart_out;
            end
            repeat (bit_cycles) @(negedge clock);
            checks++;
            assert (uart_out === 1'b1) else begin
                errors++;
                $display("FAIL %0t: reply byte %0d has a low stop bit", $time, k);
            end
        end
    endtask

    task automatic run_cmd(input calc_pkg::calc_cmd_t c, input string what);
        calc_pkg::calc_wide_t got;
        fork
            send_cmd(c);
            recv_result(got);
        join
        check_equal(what, got, model_result(c));
    endtask

    task automatic expect_quiet(input int periods, input string what);
        logic quiet;
        quiet = 1'b1;
        repeat (periods * bit_cycles) begin
            @(negedge clock);
            if (uart_out !== 1'b1) begin
                quiet = 1'b0;
            end
        end
        checks++;
        assert (quiet) else begin
            errors++;
            $display("unexpected activity on uart_out %s", what);
        end
    endtask

    task automatic reset_state();
        repeat (20) begin
            @(negedge clock);
            check_equal("uart_out after reset", 64'(uart_out), 64'd1);
            check_equal("word_count after reset", 64'(word_count), 64'd0);
        end
    endtask

    task automatic basic_ops();
        run_cmd(make_cmd(32'h8765_4321, 32'h1234_abcd, 4'd0), "add");
        run_cmd(make_cmd(32'hffff_fff0, 32'h0000_0020, 4'd0), "add with carry out");
        run_cmd(make_cmd(32'h8765_4321, 32'h1234_abcd, 4'd1), "sub");
        run_cmd(make_cmd(32'h0000_0005, 32'h0000_0007, 4'd1), "sub with borrow");
        run_cmd(make_cmd(32'hf0f0_3c3c, 32'h0ff0_ffff, 4'd3), "and");
        run_cmd(make_cmd(32'hf0f0_3c3c, 32'h0ff0_0001, 4'd4), "or");
        run_cmd(make_cmd(32'hf0f0_3c3c, 32'h0ff0_ffff, 4'd5), "xor");
    endtask

    task automatic mul_and_shifts();
        logic [31:0] amounts [3];
        amounts = '{32'd0, 32'd1, 32'd31};
        run_cmd(make_cmd(32'hffff_ffff, 32'hffff_fffe, 4'd2), "mul of large values");
        run_cmd(make_cmd(32'h1234_5678, 32'h9abc_def0, 4'd2), "mul");
        for (int i = 0; i < 3; i++) begin
            run_cmd(make_cmd(32'hc000_0003, amounts[i], 4'd6), $sformatf("shl %0d", amounts[i]));
            run_cmd(make_cmd(32'hc000_0003, amounts[i], 4'd7), $sformatf("shr %0d", amounts[i]));
        end
    endtask

    task automatic word_count_steps();
        calc_pkg::calc_cmd_t c;
        calc_pkg::calc_wide_t got;
        c = make_cmd(32'h0000_1234, 32'h0000_0100, 4'd2);
        send_word(c.a);
        check_equal("word_count after word 1", 64'(word_count), 64'd1);
        send_word(c.b);
        check_equal("word_count after word 2", 64'(word_count), 64'd2);
        fork
            begin
                send_word({28'd0, c.op});
                check_equal("word_count after word 3", 64'(word_count), 64'd0);
            end
            recv_result(got);
        join
        check_equal("mul during word count test", got, model_result(c));
    endtask

    // A word and a half, then a long idle line drops the fragment
    task automatic idle_resync();
        send_word(32'h1111_2222);
        send_byte(8'h33);
        send_byte(8'h44);
        check_equal("word_count with partial command", 64'(word_count), 64'd1);
        expect_quiet(40, "while the line is idle");
        check_equal("word_count after idle line", 64'(word_count), 64'd0);
        run_cmd(make_cmd(32'h0bad_cafe, 32'h0000_1001, 4'd0), "add after resync");
        expect_quiet(30, "after the resync reply");
    endtask

    task automatic random_commands();
        calc_pkg::calc_cmd_t cmds [random_cmds];
        calc_pkg::calc_wide_t got;
        for (int i = 0; i < random_cmds; i++) begin
            cmds[i] = make_cmd($random(seed), $random(seed), 4'($random(seed)));
        end
        // Make sure unknown codes show up
        cmds[3].op = calc_pkg::calc_op_t'(4'hb);
        cmds[11].op = calc_pkg::calc_op_t'(4'hf);
        fork
            begin
                for (int i = 0; i < random_cmds; i++) begin
                    send_cmd(cmds[i]);
                end
            end
            begin
                for (int j = 0; j < random_cmds; j++) begin
                    recv_result(got);
                    check_equal($sformatf("random command %0d", j), got, model_result(cmds[j]));
                end
            end
        join
    endtask

    initial begin
        errors = 0;
        checks = 0;
        seed = 32'hf6f3;
        rst = 1'b1;
        uart_in = 1'b1;
        repeat (2) @(negedge clock);
        rst = 1'b0;
        reset_state();
        basic_ops();
        mul_and_shifts();
        word_count_steps();
        idle_resync();
        random_commands();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
